// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       := ex1_tb
FILELIST  := ex1_top.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(wildcard logic/*.sv logic/*.svh tests/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: ex1_top.f
+incdir+logic
logic/ex1_pkg.sv
logic/ex1_forward.sv
logic/ex1_alu.sv
logic/ex1_branch.sv
logic/ex1_stage.sv
logic/ex1_ex2_reg.sv
logic/ex1_top.sv
tests/ex1_tb.sv

// File: logic/ex1_alu.sv
`include "ex1_macros.svh"

module ex1_alu import ex1_pkg::*; (
    input  alu_op_e              op_i,
    input  logic [`EX1_XLEN-1:0] a_i,
    input  logic [`EX1_XLEN-1:0] b_i,
    output logic [`EX1_XLEN-1:0] y_o
);

    logic [4:0] shamt;

    // only the low bits of b count for shifts
    assign shamt = b_i[4:0];

    always_comb begin
        y_o = '0;
        unique case (op_i)
            ALU_ADD:    y_o = a_i + b_i;
            ALU_SUB:    y_o = a_i - b_i;
            ALU_SLT:    y_o[0] = $signed(a_i) < $signed(b_i);
            ALU_SLTU:   y_o[0] = a_i < b_i;
            ALU_AND:    y_o = a_i & b_i;
            ALU_OR:     y_o = a_i | b_i;
            ALU_XOR:    y_o = a_i ^ b_i;
            ALU_NOR:    y_o = ~(a_i | b_i);
            ALU_SLL:    y_o = a_i << shamt;
            ALU_SRL:    y_o = a_i >> shamt;
            ALU_SRA:    y_o = $signed(a_i) >>> shamt;
            // lu12i style, immediate straight through
            ALU_PASS_B: y_o = b_i;
            default:    y_o = '0;
        endcase
    end

endmodule

// File: logic/ex1_branch.sv
`include "ex1_macros.svh"

module ex1_branch import ex1_pkg::*; (
    input  lane_t                lane_i,
    input  logic [`EX1_XLEN-1:0] rj_data_i,
    input  logic [`EX1_XLEN-1:0] rk_data_i,
    output branch_res_t          br_o,
    output logic                 flush_o
);

    logic                 is_br;
    logic                 cond;
    logic [`EX1_XLEN-1:0] base;
    logic [`EX1_XLEN-1:0] target;
    logic                 dir_fail;
    logic                 addr_fail;

    assign is_br = lane_i.valid && lane_i.br_op != BR_NONE;

    always_comb begin
        cond = 1'b0;
        unique case (lane_i.br_op)
            BR_BEQ:  cond = rj_data_i == rk_data_i;
            BR_BNE:  cond = rj_data_i != rk_data_i;
            BR_BLT:  cond = $signed(rj_data_i) < $signed(rk_data_i);
            BR_BGE:  cond = $signed(rj_data_i) >= $signed(rk_data_i);
            BR_BLTU: cond = rj_data_i < rk_data_i;
            BR_BGEU: cond = rj_data_i >= rk_data_i;
            BR_B, BR_BL, BR_JIRL: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign base   = (lane_i.br_op == BR_JIRL) ? rj_data_i : lane_i.pc;
    assign target = base + lane_i.imm;

    assign br_o.valid  = is_br;
    assign br_o.taken  = is_br & cond;
    assign br_o.pc     = lane_i.pc;
    assign br_o.target = target;

    // wrong direction, or right direction with a wrong target
    assign dir_fail  = br_o.taken != lane_i.pred_taken;
    assign addr_fail = br_o.taken && target != lane_i.pred_pc;
    assign flush_o   = is_br & (dir_fail | addr_fail);

endmodule

// File: logic/ex1_ex2_reg.sv
`include "ex1_macros.svh"

module ex1_ex2_reg import ex1_pkg::*; (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    input  ex1_result_t               in_result_i,
    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output ex1_result_t               out_result_o,
    output fwd_src_t [`EX1_LANES-1:0] ex2_src_o
);

    logic        full;
    logic        run;
    ex1_result_t held;

    // run keeps the input closed until reset is released
    assign in_ready_o = run & (~full | out_ready_i);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            run  <= 1'b0;
            full <= 1'b0;
        end else begin
            run <= 1'b1;
            if (in_ready_o) begin
                full <= in_valid_i;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (in_valid_i && in_ready_o) begin
            held <= in_result_i;
        end
    end

    assign out_valid_o  = full;
    assign out_result_o = held;

    for (genvar l = 0; l < `EX1_LANES; l++) begin : g_fwd
        logic wr;
        logic is_load;

        assign wr      = full & held.lane[l].writes_rd;
        // only lane 0 can carry a load
        assign is_load = (l == 0) && held.dcache.rvalid;

        // an empty or non-writing lane shows r0 so it never matches
        assign ex2_src_o[l].rd         = wr ? held.lane[l].rd : '0;
        assign ex2_src_o[l].data       = held.lane[l].result;
        assign ex2_src_o[l].data_valid = wr & ~is_load;
    end

endmodule

// File: logic/ex1_forward.sv
`include "ex1_macros.svh"

module ex1_forward import ex1_pkg::*; (
    input  logic [`EX1_RADDR_W-1:0] rj_i,
    input  logic [`EX1_RADDR_W-1:0] rk_i,
    input  logic [`EX1_XLEN-1:0]    rj_data_i,
    input  logic [`EX1_XLEN-1:0]    rk_data_i,
    input  logic                    need_rj_i,
    input  logic                    need_rk_i,
    input  fwd_src_t [1:0]          ex2_src_i,
    input  fwd_src_t [1:0]          wb_src_i,
    output logic [`EX1_XLEN-1:0]    rj_data_o,
    output logic [`EX1_XLEN-1:0]    rk_data_o,
    output logic                    stall_o
);

    // index 0 is the youngest producer and wins
    fwd_src_t [3:0] prio;
    logic           rj_stall;
    logic           rk_stall;

    assign prio = {wb_src_i[0], wb_src_i[1], ex2_src_i[0], ex2_src_i[1]};

    function automatic void resolve(
        input  logic [`EX1_RADDR_W-1:0] addr,
        input  logic [`EX1_XLEN-1:0]    rf_data,
        input  logic                    need,
        input  fwd_src_t [3:0]          srcs,
        output logic [`EX1_XLEN-1:0]    data,
        output logic                    stall
    );
        data  = rf_data;
        stall = 1'b0;
        // oldest first so a later match overrides
        for (int i = 3; i >= 0; i--) begin
            if (addr != '0 && srcs[i].rd == addr) begin
                data  = srcs[i].data;
                stall = need & ~srcs[i].data_valid;
            end
        end
    endfunction

    always_comb begin
        resolve(rj_i, rj_data_i, need_rj_i, prio, rj_data_o, rj_stall);
        resolve(rk_i, rk_data_i, need_rk_i, prio, rk_data_o, rk_stall);
    end

    assign stall_o = rj_stall | rk_stall;

endmodule

// File: logic/ex1_macros.svh
`ifndef EX1_MACROS_SVH
`define EX1_MACROS_SVH

// integer datapath width
`define EX1_XLEN 32

// architectural register index width
`define EX1_RADDR_W 5

// lanes in one issue packet
// lane 0 takes branch, memory and system work
// lane 1 is ALU only
`define EX1_LANES 2

`endif

// File: logic/ex1_pkg.sv
`include "ex1_macros.svh"

package ex1_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RF, SRC1_PC, SRC1_ZERO, SRC1_TID} src1_sel_e;

    typedef enum logic [1:0] {SRC2_RF, SRC2_IMM, SRC2_CNT_LO, SRC2_CNT_HI} src2_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_B, BR_BL, BR_JIRL
    } br_op_e;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_LD_B, MEM_LD_H, MEM_LD_W, MEM_ST_B, MEM_ST_H, MEM_ST_W
    } mem_op_e;

    // codes follow the LoongArch ecode numbering
    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ADE  = 7'h08,
        EXC_ALE  = 7'h09,
        EXC_SYS  = 7'h0b,
        EXC_BRK  = 7'h0c,
        EXC_INE  = 7'h0d,
        EXC_IPE  = 7'h0e
    } exc_code_e;

    typedef struct packed {
        logic                    valid;
        logic [`EX1_XLEN-1:0]    pc;
        logic [`EX1_XLEN-1:0]    imm;
        logic [`EX1_RADDR_W-1:0] rj;
        logic [`EX1_RADDR_W-1:0] rk;
        logic [`EX1_RADDR_W-1:0] rd;
        logic [`EX1_XLEN-1:0]    rj_data;
        logic [`EX1_XLEN-1:0]    rk_data;
        alu_op_e                 alu_op;
        src1_sel_e               src1_sel;
        src2_sel_e               src2_sel;
        logic                    is_syscall;
        logic                    is_break;
        logic                    writes_rd;
        // lane 0 only
        br_op_e                  br_op;
        mem_op_e                 mem_op;
        logic                    pred_taken;
        logic [`EX1_XLEN-1:0]    pred_pc;
    } lane_t;

    typedef struct packed {
        lane_t [`EX1_LANES-1:0] lane;
        logic                   exc_flag;
        exc_code_e              exc_code;
        logic [`EX1_XLEN-1:0]   badv;
    } issue_pkt_t;

    typedef struct packed {
        logic [`EX1_RADDR_W-1:0] rd;
        logic [`EX1_XLEN-1:0]    data;
        logic                    data_valid;
    } fwd_src_t;

    typedef struct packed {
        logic                 rvalid;
        logic                 wvalid;
        logic [3:0]           wstrb;
        mem_op_e              mem_op;
        logic [`EX1_XLEN-1:0] addr;
        logic [`EX1_XLEN-1:0] wdata;
    } dcache_req_t;

    typedef struct packed {
        logic                 valid;
        logic                 taken;
        logic [`EX1_XLEN-1:0] pc;
        logic [`EX1_XLEN-1:0] target;
    } branch_res_t;

    typedef struct packed {
        logic [`EX1_RADDR_W-1:0] rd;
        logic [`EX1_XLEN-1:0]    result;
        logic                    result_valid;
        logic                    writes_rd;
    } lane_res_t;

    typedef struct packed {
        lane_res_t [`EX1_LANES-1:0] lane;
        dcache_req_t                dcache;
        branch_res_t                br;
        logic                       flush;
        logic                       exc_flag;
        exc_code_e                  exc_code;
        logic [`EX1_XLEN-1:0]       badv;
    } ex1_result_t;

endpackage

// File: logic/ex1_stage.sv
`include "ex1_macros.svh"

module ex1_stage import ex1_pkg::*; (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic [`EX1_XLEN-1:0]         tid_i,
    input  issue_pkt_t                   pkt_i,
    input  logic                         accept_i,
    input  fwd_src_t [`EX1_LANES-1:0]    ex2_src_i,
    input  fwd_src_t [`EX1_LANES-1:0]    wb_src_i,
    output ex1_result_t                  result_o,
    output logic                         stall_o
);

    logic [63:0]                           stable_cnt;
    lane_t                                 lane0;
    logic                                  is_load0;
    logic                                  is_store0;
    logic                                  is_cond_br0;
    logic                                  rj_extra0;
    logic                                  rk_extra0;
    logic [`EX1_LANES-1:0]                 need_rj;
    logic [`EX1_LANES-1:0]                 need_rk;
    logic [`EX1_LANES-1:0]                 fwd_stall;
    logic [`EX1_LANES-1:0][`EX1_XLEN-1:0]  rj_fwd;
    logic [`EX1_LANES-1:0][`EX1_XLEN-1:0]  rk_fwd;
    logic [`EX1_LANES-1:0][`EX1_XLEN-1:0]  alu_a;
    logic [`EX1_LANES-1:0][`EX1_XLEN-1:0]  alu_b;
    logic [`EX1_LANES-1:0][`EX1_XLEN-1:0]  alu_y;
    branch_res_t                           br_res;
    logic                                  br_flush;

    // free running, read by rdcntvl/rdcntvh
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 64'd1;
        end
    end

    assign lane0       = pkt_i.lane[0];
    assign is_load0    = lane0.mem_op inside {MEM_LD_B, MEM_LD_H, MEM_LD_W};
    assign is_store0   = lane0.mem_op inside {MEM_ST_B, MEM_ST_H, MEM_ST_W};
    assign is_cond_br0 = lane0.br_op inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    // lane 0 reads registers outside the ALU select too
    assign rj_extra0   = lane0.mem_op != MEM_NONE || is_cond_br0 || lane0.br_op == BR_JIRL;
    assign rk_extra0   = is_store0 | is_cond_br0;

    for (genvar l = 0; l < `EX1_LANES; l++) begin : g_lane
        lane_t ln;

        assign ln         = pkt_i.lane[l];
        assign need_rj[l] = ln.valid & (ln.src1_sel == SRC1_RF || (l == 0 && rj_extra0));
        assign need_rk[l] = ln.valid & (ln.src2_sel == SRC2_RF || (l == 0 && rk_extra0));

        ex1_forward u_forward (
            .rj_i      (ln.rj),
            .rk_i      (ln.rk),
            .rj_data_i (ln.rj_data),
            .rk_data_i (ln.rk_data),
            .need_rj_i (need_rj[l]),
            .need_rk_i (need_rk[l]),
            .ex2_src_i (ex2_src_i),
            .wb_src_i  (wb_src_i),
            .rj_data_o (rj_fwd[l]),
            .rk_data_o (rk_fwd[l]),
            .stall_o   (fwd_stall[l])
        );

        always_comb begin
            unique case (ln.src1_sel)
                SRC1_RF:   alu_a[l] = rj_fwd[l];
                SRC1_PC:   alu_a[l] = ln.pc;
                SRC1_ZERO: alu_a[l] = '0;
                default:   alu_a[l] = tid_i;
            endcase
            unique case (ln.src2_sel)
                SRC2_RF:     alu_b[l] = rk_fwd[l];
                SRC2_IMM:    alu_b[l] = ln.imm;
                SRC2_CNT_LO: alu_b[l] = stable_cnt[31:0];
                default:     alu_b[l] = stable_cnt[63:32];
            endcase
        end

        ex1_alu u_alu (
            .op_i (ln.alu_op),
            .a_i  (alu_a[l]),
            .b_i  (alu_b[l]),
            .y_o  (alu_y[l])
        );
    end

    ex1_branch u_branch (
        .lane_i    (lane0),
        .rj_data_i (rj_fwd[0]),
        .rk_data_i (rk_fwd[0]),
        .br_o      (br_res),
        .flush_o   (br_flush)
    );

    assign stall_o = |fwd_stall;

    always_comb begin
        result_o = '0;
        for (int l = 0; l < `EX1_LANES; l++) begin
            result_o.lane[l].rd        = pkt_i.lane[l].rd;
            result_o.lane[l].result    = alu_y[l];
            result_o.lane[l].writes_rd = pkt_i.lane[l].valid & pkt_i.lane[l].writes_rd;
            // load data only exists after ex2
            result_o.lane[l].result_valid = result_o.lane[l].writes_rd & ~(l == 0 && is_load0);
        end
        // link value for bl and jirl
        if (lane0.br_op == BR_BL || lane0.br_op == BR_JIRL) begin
            result_o.lane[0].result = lane0.pc + 32'd4;
        end

        result_o.br    = br_res;
        result_o.flush = br_flush;

        // earlier stages take priority over syscall/break
        if (pkt_i.exc_flag) begin
            result_o.exc_flag = 1'b1;
            result_o.exc_code = pkt_i.exc_code;
            result_o.badv     = pkt_i.badv;
        end else if (lane0.valid && lane0.is_syscall) begin
            result_o.exc_flag = 1'b1;
            result_o.exc_code = EXC_SYS;
            result_o.badv     = lane0.pc;
        end else if (lane0.valid && lane0.is_break) begin
            result_o.exc_flag = 1'b1;
            result_o.exc_code = EXC_BRK;
            result_o.badv     = lane0.pc;
        end

        result_o.dcache.rvalid = accept_i & lane0.valid & is_load0;
        result_o.dcache.wvalid = accept_i & lane0.valid & is_store0;
        result_o.dcache.mem_op = lane0.mem_op;
        result_o.dcache.addr   = rj_fwd[0] + lane0.imm;
        result_o.dcache.wdata  = rk_fwd[0];
        unique case (lane0.mem_op)
            MEM_ST_B: result_o.dcache.wstrb = 4'b0001;
            MEM_ST_H: result_o.dcache.wstrb = 4'b0011;
            MEM_ST_W: result_o.dcache.wstrb = 4'b1111;
            default:  result_o.dcache.wstrb = 4'b0000;
        endcase
    end

endmodule

// File: logic/ex1_top.sv
`include "ex1_macros.svh"

module ex1_top import ex1_pkg::*; (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic [`EX1_XLEN-1:0]      tid_i,
    input  logic                      issue_valid_i,
    output logic                      issue_ready_o,
    input  issue_pkt_t                issue_pkt_i,
    input  fwd_src_t [`EX1_LANES-1:0] wb_fwd_i,
    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output ex1_result_t               out_result_o
);

    logic                      reg_ready;
    logic                      fwd_stall;
    logic                      accept;
    ex1_result_t               stage_result;
    fwd_src_t [`EX1_LANES-1:0] ex2_src;

    // hold issue while a needed producer is still computing
    assign issue_ready_o = reg_ready & ~fwd_stall;
    assign accept        = issue_valid_i & issue_ready_o;

    ex1_stage u_stage (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .tid_i     (tid_i),
        .pkt_i     (issue_pkt_i),
        .accept_i  (accept),
        .ex2_src_i (ex2_src),
        .wb_src_i  (wb_fwd_i),
        .result_o  (stage_result),
        .stall_o   (fwd_stall)
    );

    ex1_ex2_reg u_ex1_ex2 (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .in_valid_i   (accept),
        .in_ready_o   (reg_ready),
        .in_result_i  (stage_result),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_result_o (out_result_o),
        .ex2_src_o    (ex2_src)
    );

endmodule

// File: tests/ex1_tb.sv
module ex1_tb import ex1_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    logic        aclk = 1'b0;
    logic        aresetn;
    logic [31:0] tid_i;
    logic        issue_valid_i;
    logic        issue_ready_o;
    issue_pkt_t  issue_pkt_i;
    fwd_src_t [1:0] wb_fwd_i;
    logic        out_valid_o;
    logic        out_ready_i;
    ex1_result_t out_result_o;

    integer      seed = 94752;
    integer      ready_seed = 94752 + 1;
    int          errors = 0;
    int          checked = 0;
    logic [63:0] cnt = '0;
    ex1_result_t exp_q[$];
    ex1_result_t exp_r;
    ex1_result_t hold_val;
    logic        hold_pending = 1'b0;
    logic        ref_stall;
    logic        running = 1'b0;
    logic        reset_seen = 1'b0;
    logic        exp_ready;

    ex1_top dut_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .tid_i         (tid_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_pkt_i   (issue_pkt_i),
        .wb_fwd_i      (wb_fwd_i),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_result_o  (out_result_o)
    );

    always #5 aclk = ~aclk;

    // load data of the test memory, mixes every address bit
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'd0, a < b};
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_PASS_B: return b;
            default:  return '0;
        endcase
    endfunction

    // youngest producer first: ex1/ex2 lane 1, lane 0, then ex2/wb lane 1, lane 0
    function automatic void pick_operand(input logic [4:0] r, input logic [31:0] rf,
                                         input logic need, input fwd_src_t [1:0] ex2,
                                         input fwd_src_t [1:0] wb, output logic [31:0] d,
                                         output logic st);
        fwd_src_t order [4];
        logic     found;
        order = '{ex2[1], ex2[0], wb[1], wb[0]};
        d = rf;
        st = 1'b0;
        found = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (!found && r != 5'd0 && order[i].rd == r) begin
                found = 1'b1;
                d = order[i].data;
                st = need & ~order[i].data_valid;
            end
        end
    endfunction

    function automatic void ref_result(input issue_pkt_t p, input logic full,
                                       input ex1_result_t held, input fwd_src_t [1:0] wb,
                                       input logic [63:0] c, input logic [31:0] tid,
                                       output ex1_result_t r, output logic st);
        fwd_src_t [1:0] ex2;
        lane_t          ln;
        logic [31:0]    rj, rk, a, b, target;
        logic           need_j, need_k, sj, sk, ld, sto, cbr, cond, is_br;
        r = '0;
        st = 1'b0;
        for (int l = 0; l < 2; l++) begin
            ex2[l].rd = (full && held.lane[l].writes_rd) ? held.lane[l].rd : 5'd0;
            ex2[l].data = held.lane[l].result;
            ex2[l].data_valid = full && held.lane[l].writes_rd
                                && !(l == 0 && held.dcache.rvalid);
        end
        ln = p.lane[0];
        ld = ln.mem_op inside {MEM_LD_B, MEM_LD_H, MEM_LD_W};
        sto = ln.mem_op inside {MEM_ST_B, MEM_ST_H, MEM_ST_W};
        cbr = ln.br_op inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
        for (int l = 1; l >= 0; l--) begin
            ln = p.lane[l];
            need_j = ln.valid && (ln.src1_sel == SRC1_RF
                     || (l == 0 && (ln.mem_op != MEM_NONE || cbr || ln.br_op == BR_JIRL)));
            need_k = ln.valid && (ln.src2_sel == SRC2_RF || (l == 0 && (sto || cbr)));
            pick_operand(ln.rj, ln.rj_data, need_j, ex2, wb, rj, sj);
            pick_operand(ln.rk, ln.rk_data, need_k, ex2, wb, rk, sk);
            st = st | sj | sk;
            case (ln.src1_sel)
                SRC1_RF:   a = rj;
                SRC1_PC:   a = ln.pc;
                SRC1_ZERO: a = '0;
                default:   a = tid;
            endcase
            case (ln.src2_sel)
                SRC2_RF:     b = rk;
                SRC2_IMM:    b = ln.imm;
                SRC2_CNT_LO: b = c[31:0];
                default:     b = c[63:32];
            endcase
            r.lane[l].rd = ln.rd;
            r.lane[l].result = alu_model(ln.alu_op, a, b);
            r.lane[l].writes_rd = ln.valid && ln.writes_rd;
            r.lane[l].result_valid = ln.valid && ln.writes_rd && !(l == 0 && ld);
        end
        case (ln.br_op)
            BR_BEQ:  cond = rj == rk;
            BR_BNE:  cond = rj != rk;
            BR_BLT:  cond = $signed(rj) < $signed(rk);
            BR_BGE:  cond = $signed(rj) >= $signed(rk);
            BR_BLTU: cond = rj < rk;
            BR_BGEU: cond = rj >= rk;
            BR_B, BR_BL, BR_JIRL: cond = 1'b1;
            default: cond = 1'b0;
        endcase
        is_br = ln.valid && ln.br_op != BR_NONE;
        target = ((ln.br_op == BR_JIRL) ? rj : ln.pc) + ln.imm;
        r.br = '{valid: is_br, taken: is_br && cond, pc: ln.pc, target: target};
        r.flush = is_br && ((r.br.taken != ln.pred_taken) || (r.br.taken && target != ln.pred_pc));
        if (ln.br_op == BR_BL || ln.br_op == BR_JIRL) begin
            r.lane[0].result = ln.pc + 32'd4;
        end
        r.dcache.rvalid = ln.valid && ld;
        r.dcache.wvalid = ln.valid && sto;
        r.dcache.mem_op = ln.mem_op;
        r.dcache.addr = rj + ln.imm;
        r.dcache.wdata = rk;
        r.dcache.wstrb = (ln.mem_op == MEM_ST_B) ? 4'b0001 : (ln.mem_op == MEM_ST_H) ? 4'b0011 :
                         (ln.mem_op == MEM_ST_W) ? 4'b1111 : 4'b0000;
        if (p.exc_flag) begin
            r.exc_flag = 1'b1;
            r.exc_code = p.exc_code;
            r.badv = p.badv;
        end else if (ln.valid && (ln.is_syscall || ln.is_break)) begin
            r.exc_flag = 1'b1;
            r.exc_code = ln.is_syscall ? EXC_SYS : EXC_BRK;
            r.badv = ln.pc;
        end
    endfunction

    // what the ex2/wb model forwards one cycle after taking a result
    function automatic fwd_src_t [1:0] wb_from(input ex1_result_t r);
        fwd_src_t [1:0] w;
        for (int l = 0; l < 2; l++) begin
            w[l].rd = r.lane[l].writes_rd ? r.lane[l].rd : 5'd0;
            w[l].data = (l == 0 && r.dcache.rvalid) ? mem_word(r.dcache.addr) : r.lane[l].result;
            w[l].data_valid = r.lane[l].writes_rd;
        end
        return w;
    endfunction

    task automatic build_pkt(output issue_pkt_t p);
        lane_t       ln;
        logic [31:0] r;
        p = '0;
        for (int l = 0; l < 2; l++) begin
            ln = '0;
            r = $random(seed);
            ln.valid = (l == 0) || (r[1:0] != 2'd0);
            ln.rj = {2'b00, r[4:2]};
            ln.rk = {2'b00, r[7:5]};
            ln.rd = {2'b00, r[10:8]};
            ln.src1_sel = src1_sel_e'(r[12:11]);
            ln.src2_sel = src2_sel_e'(r[14:13]);
            ln.writes_rd = r[15];
            ln.alu_op = alu_op_e'(4'(r[31:16] % 12));
            r = $random(seed);
            ln.imm = {{20{r[11]}}, r[11:0]};
            ln.pc = {r[31:14], 12'd0, 2'b00} + {18'd0, r[13:12], 12'd0};
            ln.rj_data = $random(seed);
            ln.rk_data = $random(seed);
            if (l == 0) begin
                r = $random(seed);
                case (r[2:0])
                    3'd0, 3'd1: begin
                        ln.br_op = br_op_e'(4'(1 + r[15:8] % 9));
                        ln.writes_rd = ln.br_op inside {BR_BL, BR_JIRL};
                        ln.pred_taken = r[3];
                        ln.pred_pc = r[4] ? ln.pc + ln.imm : {r[31:18], 18'd0};
                    end
                    3'd2: begin
                        ln.mem_op = mem_op_e'(3'(1 + r[15:8] % 3));
                        ln.writes_rd = 1'b1;
                    end
                    3'd3: begin
                        ln.mem_op = mem_op_e'(3'(4 + r[15:8] % 3));
                        ln.writes_rd = 1'b0;
                    end
                    default: ;
                endcase
                ln.is_syscall = r[19:16] == 4'd0;
                ln.is_break = r[19:16] == 4'd1;
                p.exc_flag = r[23:20] == 4'd0;
                p.exc_code = r[24] ? EXC_ADE : (r[25] ? EXC_ALE : EXC_INE);
                p.badv = $random(seed);
            end
            p.lane[l] = ln;
        end
    endtask

    // compares every output transfer, tracks forwarding state and models ex2/wb
    always @(posedge aclk) begin
        if (hold_pending) begin
            assert (out_valid_o && out_result_o == hold_val) else begin
                errors++;
                $display("Fail hold: expected %h, actual %h", hold_val, out_result_o);
            end
        end
        hold_pending = out_valid_o && !out_ready_i;
        hold_val = out_result_o;
        ref_result(issue_pkt_i, exp_q.size() != 0, exp_q.size() != 0 ? exp_q[0] : '0,
                   wb_fwd_i, cnt, tid_i, exp_r, ref_stall);
        if (reset_seen) begin
            assert (out_valid_o == (exp_q.size() != 0)) else begin
                errors++;
                $display("Fail out_valid: expected %b, actual %b",
                         exp_q.size() != 0, out_valid_o);
            end
            // issue closes while the entry cannot leave or an operand is missing
            exp_ready = running && (exp_q.size() == 0 || out_ready_i) && !ref_stall;
            assert (issue_ready_o == exp_ready) else begin
                errors++;
                $display("Fail issue_ready: expected %b, actual %b", exp_ready, issue_ready_o);
            end
        end
        if (out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("output transfer with no packet outstanding");
            end else begin
                assert (out_result_o == exp_q[0]) else begin
                    errors++;
                    $display("Fail packet %0d: expected %h, actual %h",
                             checked, exp_q[0], out_result_o);
                end
                void'(exp_q.pop_front());
                checked++;
            end
            wb_fwd_i <= wb_from(out_result_o);
        end else begin
            wb_fwd_i <= '0;
        end
        if (issue_valid_i && issue_ready_o) begin
            exp_q.push_back(exp_r);
        end
        cnt = aresetn ? cnt + 64'd1 : 64'd0;
        running = aresetn;
        reset_seen = reset_seen || !aresetn;
        out_ready_i <= aresetn && ($random(ready_seed) & 3) != 0;
    end

    task automatic wait_accept(output logic ok);
        int waits;
        waits = 0;
        do begin
            @(posedge aclk);
            waits++;
        end while (!(issue_valid_i && issue_ready_o) && waits < 200);
        ok = issue_valid_i && issue_ready_o;
    endtask

    initial begin
        issue_pkt_t p;
        logic       ok;
        int         waits;
        aresetn <= 1'b0;
        tid_i <= 32'h0000_0abc;
        issue_valid_i <= 1'b0;
        issue_pkt_i <= '0;
        wb_fwd_i <= '0;
        out_ready_i <= 1'b0;
        repeat (5) @(posedge aclk);
        aresetn <= 1'b1;
        ok = 1'b1;
        @(posedge aclk);
        build_pkt(p);
        issue_valid_i <= 1'b1;
        issue_pkt_i <= p;
        for (int n = 0; n < 500 && ok; n++) begin
            wait_accept(ok);
            if (!ok) begin
                $display("issue handshake timed out at packet %0d", n);
                errors++;
            end else if (($random(seed) & 7) == 0) begin
                issue_valid_i <= 1'b0;
                @(posedge aclk);
            end
            build_pkt(p);
            issue_valid_i <= 1'b1;
            issue_pkt_i <= p;
        end
        issue_valid_i <= 1'b0;
        waits = 0;
        while (ok && exp_q.size() != 0 && waits < 200) begin
            @(posedge aclk);
            waits++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("output drain timed out with %0d packets outstanding", exp_q.size());
        end
        $display("errors: %0d, packets checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
